/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_execute
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* source/alu_core.sv */
`timescale 1ns/100ps

module alu_core import arm_isa_pkg::*; (
	alu_if.alu alu
);

	logic [31:0] add_a;
	logic [31:0] add_b;
	logic add_cin;
	logic use_adder;
	logic [32:0] add_sum;
	logic add_ovf;
	logic [31:0] res;
	logic flag_c;
	logic flag_v;

	// every arithmetic opcode is folded onto one adder with inverted operands
	always_comb begin
		add_a = alu.in0;
		add_b = alu.in1;
		add_cin = 1'b0;
		use_adder = 1'b1;
		case (alu.op)
			ALU_SUB, ALU_CMP: begin
				add_b = ~alu.in1; // a - b as a + ~b + 1
				add_cin = 1'b1;
			end
			ALU_RSB: begin
				add_a = alu.in1;
				add_b = ~alu.in0;
				add_cin = 1'b1;
			end
			ALU_ADD, ALU_CMN: add_cin = 1'b0;
			ALU_ADC: add_cin = alu.cpsr[CPSR_C];
			ALU_SBC: begin
				add_b = ~alu.in1;
				add_cin = alu.cpsr[CPSR_C]; // borrow is the inverted carry
			end
			ALU_RSC: begin
				add_a = alu.in1;
				add_b = ~alu.in0;
				add_cin = alu.cpsr[CPSR_C];
			end
			default: use_adder = 1'b0;
		endcase
	end

	assign add_sum = {1'b0, add_a} + {1'b0, add_b} + {32'd0, add_cin};
	assign add_ovf = (add_a[31] == add_b[31]) && (add_sum[31] != add_a[31]);

	always_comb begin
		case (alu.op)
			ALU_AND, ALU_TST: res = alu.in0 & alu.in1;
			ALU_EOR, ALU_TEQ: res = alu.in0 ^ alu.in1;
			ALU_ORR: res = alu.in0 | alu.in1;
			ALU_MOV: res = alu.in1;
			ALU_BIC: res = alu.in0 & ~alu.in1;
			ALU_MVN: res = ~alu.in1;
			default: res = add_sum[31:0];
		endcase
	end

	// logical ops take C from the shifter and leave V alone
	assign flag_c = use_adder ? add_sum[32] : alu.shifter_carry;
	assign flag_v = use_adder ? add_ovf : alu.cpsr[CPSR_V];

	assign alu.result = res;
	assign alu.setres = !(alu.op inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN});
	assign alu.cpsr_out = alu.setflags ?
		{res[31], res == 32'd0, flag_c, flag_v, alu.cpsr[CPSR_V-1:0]} : alu.cpsr;

	always_comb begin
		if (!$isunknown(alu.op))
			assert (!$isunknown(alu.setres))
				else $error("setres unknown for opcode %h", alu.op);
	end

endmodule

/* source/arm_isa_pkg.sv */
package arm_isa_pkg;

	// psr flag positions
	localparam int CPSR_N = 31;
	localparam int CPSR_Z = 30;
	localparam int CPSR_C = 29;
	localparam int CPSR_V = 28;

	localparam logic [4:0] MODE_USR = 5'b10000;

	// class patterns as value and care mask, tried in this order by the decoder
	localparam logic [31:0] DEC_MULT_VAL = 32'h0000_0090;
	localparam logic [31:0] DEC_MULT_MASK = 32'h0FC0_00F0;
	localparam logic [31:0] DEC_MRS_VAL = 32'h010F_0000;
	localparam logic [31:0] DEC_MRS_MASK = 32'h0FBF_0FFF;
	localparam logic [31:0] DEC_MSR_VAL = 32'h0129_F000;
	localparam logic [31:0] DEC_MSR_MASK = 32'h0FBF_FFF0;
	localparam logic [31:0] DEC_MSR_FLAGS_VAL = 32'h0128_F000; // register or immediate source
	localparam logic [31:0] DEC_MSR_FLAGS_MASK = 32'h0DBF_F000;
	localparam logic [31:0] DEC_SWP_VAL = 32'h0100_0090;
	localparam logic [31:0] DEC_SWP_MASK = 32'h0FB0_0FF0;
	localparam logic [31:0] DEC_BX_VAL = 32'h012F_FF10; // bit 5 selects the link form
	localparam logic [31:0] DEC_BX_MASK = 32'h0FFF_FFD0;
	localparam logic [31:0] DEC_HDATA_REG_VAL = 32'h0000_0090;
	localparam logic [31:0] DEC_HDATA_REG_MASK = 32'h0E40_0F90;
	localparam logic [31:0] DEC_HDATA_IMM_VAL = 32'h0040_0090;
	localparam logic [31:0] DEC_HDATA_IMM_MASK = 32'h0E40_0090;
	localparam logic [31:0] DEC_ALU_VAL = 32'h0000_0000;
	localparam logic [31:0] DEC_ALU_MASK = 32'h0C00_0000;
	localparam logic [31:0] DEC_LDRSTR_VAL = 32'h0400_0000;
	localparam logic [31:0] DEC_LDRSTR_MASK = 32'h0C00_0000;
	localparam logic [31:0] DEC_LDMSTM_VAL = 32'h0800_0000;
	localparam logic [31:0] DEC_LDMSTM_MASK = 32'h0E00_0000;
	localparam logic [31:0] DEC_BRANCH_VAL = 32'h0A00_0000;
	localparam logic [31:0] DEC_BRANCH_MASK = 32'h0E00_0000;

	// data-processing opcodes, bits 24:21 of the word
	localparam logic [3:0] ALU_AND = 4'h0;
	localparam logic [3:0] ALU_EOR = 4'h1;
	localparam logic [3:0] ALU_SUB = 4'h2;
	localparam logic [3:0] ALU_RSB = 4'h3;
	localparam logic [3:0] ALU_ADD = 4'h4;
	localparam logic [3:0] ALU_ADC = 4'h5;
	localparam logic [3:0] ALU_SBC = 4'h6;
	localparam logic [3:0] ALU_RSC = 4'h7;
	localparam logic [3:0] ALU_TST = 4'h8;
	localparam logic [3:0] ALU_TEQ = 4'h9;
	localparam logic [3:0] ALU_CMP = 4'hA;
	localparam logic [3:0] ALU_CMN = 4'hB;
	localparam logic [3:0] ALU_ORR = 4'hC;
	localparam logic [3:0] ALU_MOV = 4'hD;
	localparam logic [3:0] ALU_BIC = 4'hE;
	localparam logic [3:0] ALU_MVN = 4'hF;

	// the multiply destination lands in the rn slot of the dp view
	typedef union packed {
		struct packed {
			logic [3:0] cond;
			logic [1:0] cls;
			logic imm;
			logic [3:0] opcode;
			logic s;
			logic [3:0] rn;
			logic [3:0] rd;
			logic [11:0] operand2;
		} dp;
		struct packed {
			logic [3:0] cond;
			logic [5:0] zero;
			logic a;
			logic s;
			logic [3:0] rd;
			logic [3:0] rn;
			logic [3:0] rs;
			logic [3:0] marker; // always 4'b1001
			logic [3:0] rm;
		} mul;
	} instr_word_u;

	function automatic logic insn_match(input logic [31:0] word, input logic [31:0] value,
			input logic [31:0] mask);
		return (word & mask) == value;
	endfunction

endpackage

/* source/exec_ifs.sv */
`timescale 1ns/100ps

// combinational path from the stage to the data-processing unit
interface alu_if;
	logic [31:0] in0;
	logic [31:0] in1;
	logic [31:0] cpsr;
	logic [3:0] op;
	logic setflags;
	logic shifter_carry;
	logic [31:0] result;
	logic [31:0] cpsr_out;
	logic setres; // low for the compare and test opcodes

	modport stage (
		output in0, in1, cpsr, op, setflags, shifter_carry,
		input result, cpsr_out, setres
	);

	modport alu (
		input in0, in1, cpsr, op, setflags, shifter_carry,
		output result, cpsr_out, setres
	);
endinterface

// start is a single-cycle pulse, done a level that holds until the next start
interface mult_if;
	logic start;
	logic [31:0] acc0;
	logic [31:0] in0;
	logic [31:0] in1;
	logic done;
	logic [31:0] result;

	modport stage (
		output start, acc0, in0, in1,
		input done, result
	);

	modport mult (
		input start, acc0, in0, in1,
		output done, result
	);
endinterface

/* source/exec_pipe_pkg.sv */
package exec_pipe_pkg;

	// register numbers with a fixed role in the stage
	localparam logic [3:0] LINK_REG = 4'd14;
	localparam logic [3:0] PC_REG = 4'd15; // an S op writing here restores spsr

	// the pc seen in execute runs two words ahead of the instruction
	localparam logic [31:0] PC_LINK_OFFSET = 32'd4; // return address saved by BL and BLX
	localparam logic [31:0] PC_BRANCH_OFFSET = 32'd8;

endpackage

/* source/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage import arm_isa_pkg::*, exec_pipe_pkg::*; (
	input logic clk,
	input logic rst_b,
	input logic stall_2a,
	input logic flush_2a,
	input logic bubble_2a,
	input logic carry_2a,
	input logic [31:0] pc_2a,
	input logic [31:0] insn_2a,
	input logic [31:0] cpsr_2a,
	input logic [31:0] spsr_2a,
	input logic [31:0] op0_2a,
	input logic [31:0] op1_2a,
	input logic [31:0] op2_2a,
	alu_if.stage alu,
	mult_if.stage mul,
	output logic outstall_2a,
	output logic bubble_3a,
	output logic [31:0] cpsr_3a,
	output logic [31:0] spsr_3a,
	output logic cpsrup_3a,
	output logic write_reg_3a,
	output logic [3:0] write_num_3a,
	output logic [31:0] write_data_3a,
	output logic jmp_2a,
	output logic [31:0] jmppc_2a,
	output logic [31:0] pc_3a,
	output logic [31:0] insn_3a,
	output logic [31:0] op0_3a,
	output logic [31:0] op1_3a,
	output logic [31:0] op2_3a
);

	instr_word_u insn;
	logic is_mult;
	logic is_mrs;
	logic is_msr;
	logic is_bx;
	logic is_alu;
	logic is_branch;
	logic psr_sel; // Ps bit, set selects spsr
	logic msr_flags_only;
	logic outstall_3a; // stall seen on the previous cycle
	logic delayed_flush_2a;
	logic raw_write;
	logic raw_cpsrup;
	logic next_bubble_3a;
	logic [31:0] next_cpsr_3a;
	logic [31:0] next_spsr_3a;
	logic [3:0] next_write_num_3a;
	logic [31:0] next_write_data_3a;

	assign insn = insn_2a;
	assign psr_sel = insn_2a[22];
	assign msr_flags_only = (cpsr_2a[4:0] == MODE_USR) || !insn_2a[16];

	// multiply has to win over ALU since its pattern is a corner of the ALU space
	always_comb begin
		is_mult = 1'b0;
		is_mrs = 1'b0;
		is_msr = 1'b0;
		is_bx = 1'b0;
		is_alu = 1'b0;
		is_branch = 1'b0;
		if (insn_match(insn_2a, DEC_MULT_VAL, DEC_MULT_MASK))
			is_mult = 1'b1;
		else if (insn_match(insn_2a, DEC_MRS_VAL, DEC_MRS_MASK))
			is_mrs = 1'b1;
		else if (insn_match(insn_2a, DEC_MSR_VAL, DEC_MSR_MASK) ||
				insn_match(insn_2a, DEC_MSR_FLAGS_VAL, DEC_MSR_FLAGS_MASK))
			is_msr = 1'b1;
		else if (insn_match(insn_2a, DEC_SWP_VAL, DEC_SWP_MASK)) begin
		end
		else if (insn_match(insn_2a, DEC_BX_VAL, DEC_BX_MASK))
			is_bx = 1'b1;
		else if (insn_match(insn_2a, DEC_HDATA_REG_VAL, DEC_HDATA_REG_MASK) ||
				insn_match(insn_2a, DEC_HDATA_IMM_VAL, DEC_HDATA_IMM_MASK)) begin
		end
		else if (insn_match(insn_2a, DEC_ALU_VAL, DEC_ALU_MASK))
			is_alu = 1'b1;
		else if (insn_match(insn_2a, DEC_LDRSTR_VAL, DEC_LDRSTR_MASK) ||
				insn_match(insn_2a, DEC_LDMSTM_VAL, DEC_LDMSTM_MASK)) begin
		end
		else if (insn_match(insn_2a, DEC_BRANCH_VAL, DEC_BRANCH_MASK))
			is_branch = 1'b1;
	end

	assign alu.in0 = op0_2a;
	assign alu.in1 = op1_2a;
	assign alu.cpsr = cpsr_2a;
	assign alu.op = insn.dp.opcode;
	assign alu.setflags = insn.dp.s;
	assign alu.shifter_carry = carry_2a;

	// a new multiply starts only on its first cycle in 2a
	assign mul.start = is_mult && !bubble_2a && !outstall_3a;
	assign mul.acc0 = insn.mul.a ? op2_2a : 32'd0;
	assign mul.in0 = op0_2a; // rm
	assign mul.in1 = op1_2a; // rs

	assign outstall_2a = stall_2a || (is_mult && !bubble_2a && (!outstall_3a || !mul.done));

	always_comb begin
		next_cpsr_3a = cpsr_2a;
		next_spsr_3a = spsr_2a;
		raw_cpsrup = 1'b0;
		raw_write = 1'b0;
		next_write_num_3a = 4'd0;
		next_write_data_3a = 32'd0;
		if (is_mult) begin
			raw_write = 1'b1;
			next_write_num_3a = insn.mul.rd;
			next_write_data_3a = mul.result;
			if (insn.mul.s) begin
				raw_cpsrup = 1'b1;
				next_cpsr_3a[CPSR_N] = mul.result[31];
				next_cpsr_3a[CPSR_Z] = (mul.result == 32'd0);
				next_cpsr_3a[CPSR_C] = 1'b0; // V is kept
			end
		end else if (is_mrs) begin
			raw_write = 1'b1;
			next_write_num_3a = insn.dp.rd;
			next_write_data_3a = psr_sel ? spsr_2a : cpsr_2a;
		end else if (is_msr) begin
			raw_cpsrup = 1'b1;
			if (msr_flags_only && psr_sel)
				next_spsr_3a[CPSR_N:CPSR_C] = op0_2a[CPSR_N:CPSR_C];
			else if (msr_flags_only)
				next_cpsr_3a[CPSR_N:CPSR_C] = op0_2a[CPSR_N:CPSR_C];
			else if (psr_sel)
				next_spsr_3a = op0_2a;
			else
				next_cpsr_3a = op0_2a;
		end else if (is_alu) begin
			raw_write = alu.setres;
			next_write_num_3a = insn.dp.rd;
			next_write_data_3a = alu.result;
			if (insn.dp.s) begin
				raw_cpsrup = 1'b1;
				next_cpsr_3a = (insn.dp.rd == PC_REG) ? spsr_2a : alu.cpsr_out; // exception return
			end
		end else if ((is_bx && insn_2a[5]) || (is_branch && insn_2a[24])) begin
			raw_write = 1'b1;
			next_write_num_3a = LINK_REG;
			next_write_data_3a = pc_2a + PC_LINK_OFFSET;
		end
	end

	// an unfinished multiply keeps sending bubbles while it stalls the stage
	assign next_bubble_3a = bubble_2a || flush_2a || delayed_flush_2a ||
		(is_mult && (!mul.done || !outstall_3a));

	// jumps yield to anything that would hold or kill this instruction
	assign jmp_2a = (is_bx || is_branch) && !bubble_2a && !flush_2a &&
		!delayed_flush_2a && !outstall_2a;
	assign jmppc_2a = !jmp_2a ? 32'd0 :
		is_bx ? op0_2a : pc_2a + op0_2a + PC_BRANCH_OFFSET;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			outstall_3a <= 1'b0;
			delayed_flush_2a <= 1'b0;
		end else begin
			outstall_3a <= outstall_2a;
			if (flush_2a && outstall_2a)
				delayed_flush_2a <= 1'b1; // apply it once the stall is over
			else if (!outstall_2a)
				delayed_flush_2a <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			bubble_3a <= 1'b1;
			cpsr_3a <= 32'd0;
			spsr_3a <= 32'd0;
			cpsrup_3a <= 1'b0;
			write_reg_3a <= 1'b0;
			write_num_3a <= 4'd0;
			write_data_3a <= 32'd0;
			pc_3a <= 32'd0;
			insn_3a <= 32'd0;
			op0_3a <= 32'd0;
			op1_3a <= 32'd0;
			op2_3a <= 32'd0;
		end else if (!stall_2a) begin
			bubble_3a <= next_bubble_3a;
			cpsr_3a <= next_cpsr_3a;
			spsr_3a <= next_spsr_3a;
			cpsrup_3a <= raw_cpsrup && !next_bubble_3a;
			write_reg_3a <= raw_write && !next_bubble_3a;
			write_num_3a <= next_write_num_3a;
			write_data_3a <= next_write_data_3a;
			pc_3a <= pc_2a;
			insn_3a <= insn_2a;
			op0_3a <= op0_2a;
			op1_3a <= op1_2a;
			op2_3a <= op2_2a;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_b) jmp_2a |-> !bubble_2a);
	assert property (@(posedge clk) disable iff (!rst_b) write_reg_3a |-> !bubble_3a);

endmodule

/* source/execute_top.sv */
`timescale 1ns/100ps

module execute_top #(
	parameter int MULT_RADIX_BITS = 2
) (
	input logic clk,
	input logic rst_b,
	input logic stall_2a,
	input logic flush_2a,
	input logic bubble_2a,
	input logic [31:0] pc_2a,
	input logic [31:0] insn_2a,
	input logic [31:0] cpsr_2a,
	input logic [31:0] spsr_2a,
	input logic [31:0] op0_2a,
	input logic [31:0] op1_2a,
	input logic [31:0] op2_2a,
	input logic carry_2a,
	output logic outstall_2a,
	output logic bubble_3a,
	output logic [31:0] cpsr_3a,
	output logic [31:0] spsr_3a,
	output logic cpsrup_3a,
	output logic write_reg_3a,
	output logic [3:0] write_num_3a,
	output logic [31:0] write_data_3a,
	output logic jmp_2a,
	output logic [31:0] jmppc_2a,
	output logic [31:0] pc_3a,
	output logic [31:0] insn_3a,
	output logic [31:0] op0_3a,
	output logic [31:0] op1_3a,
	output logic [31:0] op2_3a
);

	alu_if u_alu_if ();
	mult_if u_mult_if ();

	execute_stage u_execute_stage (
		.clk(clk), .rst_b(rst_b),
		.stall_2a(stall_2a), .flush_2a(flush_2a), .bubble_2a(bubble_2a), .carry_2a(carry_2a),
		.pc_2a(pc_2a), .insn_2a(insn_2a), .cpsr_2a(cpsr_2a), .spsr_2a(spsr_2a),
		.op0_2a(op0_2a), .op1_2a(op1_2a), .op2_2a(op2_2a),
		.alu(u_alu_if.stage), .mul(u_mult_if.stage),
		.outstall_2a(outstall_2a), .bubble_3a(bubble_3a),
		.cpsr_3a(cpsr_3a), .spsr_3a(spsr_3a), .cpsrup_3a(cpsrup_3a),
		.write_reg_3a(write_reg_3a), .write_num_3a(write_num_3a), .write_data_3a(write_data_3a),
		.jmp_2a(jmp_2a), .jmppc_2a(jmppc_2a),
		.pc_3a(pc_3a), .insn_3a(insn_3a), .op0_3a(op0_3a), .op1_3a(op1_3a), .op2_3a(op2_3a)
	);

	alu_core u_alu_core (
		.alu(u_alu_if.alu)
	);

	iter_multiplier #(
		.MULT_RADIX_BITS(MULT_RADIX_BITS)
	) u_iter_multiplier (
		.clk(clk),
		.rst_b(rst_b),
		.mul(u_mult_if.mult)
	);

endmodule

/* source/iter_multiplier.sv */
`timescale 1ns/100ps

module iter_multiplier #(
	parameter int MULT_RADIX_BITS = 2 // multiplier bits retired each cycle, 1, 2 or 4
) (
	input logic clk,
	input logic rst_b,
	mult_if.mult mul
);

	logic busy;
	logic [31:0] bitfield; // multiplier bits not yet retired
	logic [31:0] multiplicand;
	logic [31:0] acc;
	logic [31:0] pp_sum;

	// partial products of the low bits still waiting in bitfield
	always_comb begin
		pp_sum = 32'd0;
		for (int i = 0; i < MULT_RADIX_BITS; i++) begin
			if (bitfield[i])
				pp_sum = pp_sum + (multiplicand << i);
		end
	end

	// the run ends one cycle after the last set multiplier bit is consumed
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			busy <= 1'b0;
			mul.done <= 1'b0;
		end else if (mul.start) begin
			busy <= 1'b1;
			mul.done <= 1'b0;
		end else if (busy && bitfield == 32'd0) begin
			busy <= 1'b0;
			mul.done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mul.start) begin
			bitfield <= mul.in0;
			multiplicand <= mul.in1;
			acc <= mul.acc0;
		end else if (busy) begin
			bitfield <= bitfield >> MULT_RADIX_BITS;
			multiplicand <= multiplicand << MULT_RADIX_BITS; // product wraps to the low word
			acc <= acc + pp_sum;
		end
	end

	assign mul.result = acc; // frozen once busy drops

	// a second start must wait for the stage to see done
	assert property (@(posedge clk) disable iff (!rst_b) (busy && !mul.done) |-> !mul.start);

endmodule

/* tb.f */
source/arm_isa_pkg.sv
source/exec_pipe_pkg.sv
source/exec_ifs.sv
source/alu_core.sv
source/iter_multiplier.sv
source/execute_stage.sv
source/execute_top.sv
verification/exec_checker.sv
verification/tb_execute.sv

/* verification/exec_checker.sv */
`timescale 1ns/100ps

module exec_checker (
	input logic clk,
	input logic compare,
	input logic timed_out,
	input int test_id,
	input logic bubble_3a,
	input logic write_reg_3a,
	input logic [3:0] write_num_3a,
	input logic [31:0] write_data_3a,
	input logic [31:0] cpsr_3a,
	input logic [31:0] spsr_3a,
	input logic cpsrup_3a,
	input logic jmp_2a,
	input logic [31:0] jmppc_2a,
	input logic stalled, // outstall_2a was seen high before the capture edge
	input logic [31:0] pc_3a,
	input logic [31:0] insn_3a,
	input logic [31:0] op0_3a,
	input logic [31:0] op1_3a,
	input logic [31:0] op2_3a,
	input logic exp_bubble,
	input logic exp_write,
	input logic [3:0] exp_num,
	input logic [31:0] exp_data,
	input logic [31:0] exp_cpsr,
	input logic [31:0] exp_spsr,
	input logic exp_cpsrup,
	input logic exp_jmp,
	input logic [31:0] exp_jmppc,
	input logic exp_stall,
	input logic [31:0] exp_pc,
	input logic [31:0] exp_insn,
	input logic [31:0] exp_op0,
	input logic [31:0] exp_op1,
	input logic [31:0] exp_op2,
	output int error_count,
	output int test_count
);

	logic jmp_seen; // jump outputs from the cycle before the capture edge
	logic [31:0] jmppc_seen;
	int field_errors;

	initial begin
		error_count = 0;
		test_count = 0;
		jmp_seen = 1'b0;
		jmppc_seen = 32'h0;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("MISMATCH %s: got %h expected %h", name, got, want);
			field_errors++;
		end
	endtask

	always @(negedge clk) begin
		if (compare) begin
			field_errors = 0;
			if (timed_out) begin
				$display("test %0d: outstall_2a did not fall within the wait limit", test_id);
				field_errors = 1;
			end else begin
				check_value("outstall_2a", 32'(stalled), 32'(exp_stall));
				check_value("bubble_3a", 32'(bubble_3a), 32'(exp_bubble));
				check_value("write_reg_3a", 32'(write_reg_3a), 32'(exp_write));
				check_value("cpsrup_3a", 32'(cpsrup_3a), 32'(exp_cpsrup));
				check_value("jmp_2a", 32'(jmp_seen), 32'(exp_jmp));
				// the pass-through copies are registered even for a bubble
				check_value("pc_3a", pc_3a, exp_pc);
				check_value("insn_3a", insn_3a, exp_insn);
				check_value("op0_3a", op0_3a, exp_op0);
				check_value("op1_3a", op1_3a, exp_op1);
				check_value("op2_3a", op2_3a, exp_op2);
				if (exp_write) begin
					check_value("write_num_3a", 32'(write_num_3a), 32'(exp_num));
					check_value("write_data_3a", write_data_3a, exp_data);
				end
				if (!exp_bubble) begin // a bubbled record carries no meaningful psr
					check_value("cpsr_3a", cpsr_3a, exp_cpsr);
					check_value("spsr_3a", spsr_3a, exp_spsr);
				end
				if (exp_jmp)
					check_value("jmppc_2a", jmppc_seen, exp_jmppc);
			end
			if (field_errors == 0)
				$display("test %0d: ok", test_id);
			else begin
				$display("test %0d: failed with %0d errors", test_id, field_errors);
				error_count++;
			end
			test_count++;
		end
		jmp_seen <= jmp_2a;
		jmppc_seen <= jmppc_2a;
	end

endmodule

/* verification/tb_execute.sv */
`timescale 1ns/100ps

module tb_execute import arm_isa_pkg::*, exec_pipe_pkg::*; ();

	localparam logic [31:0] SVC = 32'h0000_0013;
	localparam logic [31:0] USR = 32'h0000_0010;
	localparam logic [31:0] SPSR_DEF = 32'h5000_001F;
	localparam int WAIT_LIMIT = 64;

	typedef struct packed {
		logic [31:0] insn;
		logic [31:0] pc;
		logic [31:0] cpsr;
		logic [31:0] spsr;
		logic [31:0] op0;
		logic [31:0] op1;
		logic [31:0] op2;
		logic carry;
		logic bubble;
		logic flush;
		logic late_flush; // flush pulse on the second cycle of a multiply stall
		logic e_bubble;
		logic e_write;
		logic [3:0] e_num;
		logic [31:0] e_data;
		logic [31:0] e_cpsr;
		logic [31:0] e_spsr;
		logic e_cpsrup;
		logic e_jmp;
		logic [31:0] e_jmppc;
		logic e_stall; // multiply rows must raise outstall_2a
	} row_t;

	logic clk;
	logic rst_b;
	logic stall_2a, flush_2a, bubble_2a, carry_2a;
	logic [31:0] pc_2a, insn_2a, cpsr_2a, spsr_2a, op0_2a, op1_2a, op2_2a;
	logic outstall_2a, bubble_3a, cpsrup_3a, write_reg_3a, jmp_2a;
	logic [3:0] write_num_3a;
	logic [31:0] cpsr_3a, spsr_3a, write_data_3a, jmppc_2a;
	logic [31:0] pc_3a, insn_3a, op0_3a, op1_3a, op2_3a;

	logic compare;
	logic timed_out;
	logic stalled;
	int test_id;
	row_t exp_row;
	int error_count;
	int test_count;

	row_t r;
	row_t rows[$];
	integer seed = 19482;

	execute_top u_execute_top (
		.clk(clk), .rst_b(rst_b),
		.stall_2a(stall_2a), .flush_2a(flush_2a), .bubble_2a(bubble_2a),
		.pc_2a(pc_2a), .insn_2a(insn_2a), .cpsr_2a(cpsr_2a), .spsr_2a(spsr_2a),
		.op0_2a(op0_2a), .op1_2a(op1_2a), .op2_2a(op2_2a), .carry_2a(carry_2a),
		.outstall_2a(outstall_2a), .bubble_3a(bubble_3a),
		.cpsr_3a(cpsr_3a), .spsr_3a(spsr_3a), .cpsrup_3a(cpsrup_3a),
		.write_reg_3a(write_reg_3a), .write_num_3a(write_num_3a), .write_data_3a(write_data_3a),
		.jmp_2a(jmp_2a), .jmppc_2a(jmppc_2a),
		.pc_3a(pc_3a), .insn_3a(insn_3a), .op0_3a(op0_3a), .op1_3a(op1_3a), .op2_3a(op2_3a)
	);

	exec_checker u_exec_checker (
		.clk(clk), .compare(compare), .timed_out(timed_out), .test_id(test_id),
		.bubble_3a(bubble_3a), .write_reg_3a(write_reg_3a), .write_num_3a(write_num_3a),
		.write_data_3a(write_data_3a), .cpsr_3a(cpsr_3a), .spsr_3a(spsr_3a),
		.cpsrup_3a(cpsrup_3a), .jmp_2a(jmp_2a), .jmppc_2a(jmppc_2a),
		.stalled(stalled),
		.pc_3a(pc_3a), .insn_3a(insn_3a), .op0_3a(op0_3a), .op1_3a(op1_3a), .op2_3a(op2_3a),
		.exp_bubble(exp_row.e_bubble), .exp_write(exp_row.e_write), .exp_num(exp_row.e_num),
		.exp_data(exp_row.e_data), .exp_cpsr(exp_row.e_cpsr), .exp_spsr(exp_row.e_spsr),
		.exp_cpsrup(exp_row.e_cpsrup), .exp_jmp(exp_row.e_jmp), .exp_jmppc(exp_row.e_jmppc),
		.exp_stall(exp_row.e_stall),
		.exp_pc(exp_row.pc), .exp_insn(exp_row.insn), .exp_op0(exp_row.op0),
		.exp_op1(exp_row.op1), .exp_op2(exp_row.op2),
		.error_count(error_count), .test_count(test_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] dp_word(input logic [3:0] op, input logic s,
			input logic [3:0] rn, input logic [3:0] rd);
		return {4'hE, 2'b00, 1'b0, op, s, rn, rd, 12'h000};
	endfunction

	function automatic logic [31:0] mul_word(input logic a, input logic s, input logic [3:0] rd);
		return {4'hE, 6'd0, a, s, rd, 4'd3, 4'd1, 4'b1001, 4'd0};
	endfunction

	task automatic add_row(input logic [31:0] insn, input logic [31:0] pc,
			input logic [31:0] cpsr, input logic [31:0] op0, input logic [31:0] op1,
			input logic carry);
		r = '0;
		r.insn = insn;
		r.pc = pc;
		r.cpsr = cpsr;
		r.spsr = SPSR_DEF;
		r.op0 = op0;
		r.op1 = op1;
		r.carry = carry;
	endtask

	// a bubble or a flush on the way in always kills the record
	task automatic push_row(input logic write, input logic [3:0] num, input logic [31:0] data,
			input logic [31:0] cpsr, input logic cpsrup, input logic jmp,
			input logic [31:0] jmppc);
		r.e_bubble = r.bubble || r.flush || r.late_flush;
		r.e_write = write;
		r.e_num = num;
		r.e_data = data;
		r.e_cpsr = cpsr;
		r.e_spsr = r.spsr;
		r.e_cpsrup = cpsrup;
		r.e_jmp = jmp;
		r.e_jmppc = jmppc;
		rows.push_back(r);
	endtask

	task automatic build_table();
		logic [31:0] prod;
		logic [31:0] flags;
		// data-processing with S, flags worked out by hand
		add_row(dp_word(ALU_ADD, 1, 4'd0, 4'd1), 32'h100, SVC, 32'h7FFF_FFFF, 32'h1, 0);
		push_row(1, 4'd1, 32'h8000_0000, 32'h9000_0013, 1, 0, 0);
		add_row(dp_word(ALU_SUB, 1, 4'd0, 4'd2), 32'h104, SVC, 32'h5, 32'h5, 0);
		push_row(1, 4'd2, 32'h0, 32'h6000_0013, 1, 0, 0);
		add_row(dp_word(ALU_RSB, 1, 4'd0, 4'd3), 32'h108, SVC, 32'h1, 32'h3, 0);
		push_row(1, 4'd3, 32'h2, 32'h2000_0013, 1, 0, 0);
		add_row(dp_word(ALU_ADC, 1, 4'd0, 4'd4), 32'h10C, 32'h2000_0013, 32'hFFFF_FFFF, 32'h0, 0);
		push_row(1, 4'd4, 32'h0, 32'h6000_0013, 1, 0, 0);
		add_row(dp_word(ALU_SBC, 1, 4'd0, 4'd5), 32'h110, SVC, 32'd10, 32'd3, 0);
		push_row(1, 4'd5, 32'd6, 32'h2000_0013, 1, 0, 0);
		add_row(dp_word(ALU_AND, 1, 4'd0, 4'd6), 32'h114, SVC, 32'hF0F0_0000, 32'hFF00_0000, 1);
		push_row(1, 4'd6, 32'hF000_0000, 32'hA000_0013, 1, 0, 0);
		add_row(dp_word(ALU_ORR, 1, 4'd0, 4'd7), 32'h118, 32'h1000_0013, 32'hF0, 32'h0F, 1);
		push_row(1, 4'd7, 32'hFF, 32'h3000_0013, 1, 0, 0);
		add_row(dp_word(ALU_MVN, 1, 4'd0, 4'd8), 32'h11C, SVC, 32'h1234, 32'hFFFF_FFFF, 1);
		push_row(1, 4'd8, 32'h0, 32'h6000_0013, 1, 0, 0);
		add_row(dp_word(ALU_BIC, 1, 4'd0, 4'd9), 32'h120, SVC, 32'hFFFF_0000, 32'h0F0F_0000, 0);
		push_row(1, 4'd9, 32'hF0F0_0000, 32'h8000_0013, 1, 0, 0);
		// compares only touch the flags
		add_row(dp_word(ALU_CMP, 1, 4'd0, 4'd0), 32'h124, SVC, 32'h3, 32'h5, 0);
		push_row(0, 4'd0, 32'h0, 32'h8000_0013, 1, 0, 0);
		add_row(dp_word(ALU_CMN, 1, 4'd0, 4'd0), 32'h128, SVC, 32'hFFFF_FFFF, 32'h1, 0);
		push_row(0, 4'd0, 32'h0, 32'h6000_0013, 1, 0, 0);
		add_row(dp_word(ALU_TST, 1, 4'd0, 4'd0), 32'h12C, SVC, 32'hF0, 32'h0F, 0);
		push_row(0, 4'd0, 32'h0, 32'h4000_0013, 1, 0, 0);
		add_row(dp_word(ALU_TEQ, 1, 4'd0, 4'd0), 32'h130, SVC, 32'h8000_0000, 32'h0, 1);
		push_row(0, 4'd0, 32'h0, 32'hA000_0013, 1, 0, 0);
		add_row(dp_word(ALU_ADD, 0, 4'd0, 4'd10), 32'h134, 32'h3000_0013, 32'h2, 32'h3, 0);
		push_row(1, 4'd10, 32'h5, 32'h3000_0013, 0, 0, 0);
		add_row(dp_word(ALU_SUB, 1, 4'd0, 4'd15), 32'h138, SVC, 32'h1, 32'h1, 0);
		r.spsr = 32'hA000_0010; // exception return copies this into cpsr
		push_row(1, 4'd15, 32'h0, 32'hA000_0010, 1, 0, 0);
		// psr transfers
		add_row(32'hE10F_B000, 32'h13C, 32'h6000_0013, 0, 0, 0);
		push_row(1, 4'd11, 32'h6000_0013, 32'h6000_0013, 0, 0, 0);
		add_row(32'hE14F_C000, 32'h140, SVC, 0, 0, 0);
		push_row(1, 4'd12, SPSR_DEF, SVC, 0, 0, 0);
		add_row(32'hE129_F000, 32'h144, SVC, 32'hF000_001F, 0, 0);
		push_row(0, 4'd0, 32'h0, 32'hF000_001F, 1, 0, 0);
		add_row(32'hE129_F000, 32'h148, USR, 32'hF000_001F, 0, 0);
		push_row(0, 4'd0, 32'h0, 32'hE000_0010, 1, 0, 0);
		// branches, op0 carries the shifted offset or the BX target
		add_row(32'hEA00_0000, 32'h1000, SVC, 32'h100, 0, 0);
		push_row(0, 4'd0, 32'h0, SVC, 0, 1, 32'h1000 + 32'h100 + PC_BRANCH_OFFSET);
		add_row(32'hEB00_0000, 32'h2000, SVC, 32'hFFFF_FFF0, 0, 0);
		push_row(1, LINK_REG, 32'h2000 + PC_LINK_OFFSET, SVC, 0, 1, 32'h1FF8);
		add_row(32'hE12F_FF10, 32'h3100, SVC, 32'h3000, 0, 0);
		push_row(0, 4'd0, 32'h0, SVC, 0, 1, 32'h3000);
		add_row(32'hE12F_FF30, 32'h4000, SVC, 32'h5000, 0, 0);
		push_row(1, LINK_REG, 32'h4000 + PC_LINK_OFFSET, SVC, 0, 1, 32'h5000);
		add_row(32'hEA00_0000, 32'h5000, SVC, 32'h40, 0, 0);
		r.bubble = 1'b1;
		push_row(0, 4'd0, 32'h0, SVC, 0, 0, 0);
		add_row(32'hEB00_0000, 32'h6000, SVC, 32'h40, 0, 0);
		r.flush = 1'b1;
		push_row(0, 4'd0, 32'h0, SVC, 0, 0, 0);
		// multiplies with random operands, C and V set on the way in
		for (int i = 0; i < 4; i++) begin
			add_row(mul_word(i[0], i[1], 4'(2 + i)), 32'h7000, 32'h3000_0013,
				$random(seed), $random(seed), 0);
			r.op2 = $random(seed);
			r.e_stall = 1'b1;
			prod = r.op0 * r.op1 + (i[0] ? r.op2 : 32'd0);
			flags = i[1] ? {prod[31], prod == 32'd0, 1'b0, 1'b1, r.cpsr[27:0]} : r.cpsr;
			push_row(1, 4'(2 + i), prod, flags, i[1], 0, 0);
		end
		add_row(mul_word(1, 0, 4'd6), 32'h7100, SVC, $random(seed) | 32'h8000_0000, 32'h7, 0);
		r.late_flush = 1'b1;
		r.e_stall = 1'b1;
		push_row(0, 4'd0, 32'h0, SVC, 0, 0, 0);
	endtask

	task automatic drive_idle();
		bubble_2a <= 1'b1;
		flush_2a <= 1'b0;
		insn_2a <= 32'h0;
	endtask

	initial begin : run
		int cnt;
		logic stall_over;
		rst_b <= 1'b0;
		stall_2a <= 1'b0;
		flush_2a <= 1'b0;
		bubble_2a <= 1'b1;
		carry_2a <= 1'b0;
		pc_2a <= 32'h0;
		insn_2a <= 32'h0;
		cpsr_2a <= 32'h0;
		spsr_2a <= 32'h0;
		op0_2a <= 32'h0;
		op1_2a <= 32'h0;
		op2_2a <= 32'h0;
		compare <= 1'b0;
		timed_out <= 1'b0;
		stalled <= 1'b0;
		test_id <= 0;
		exp_row <= '0;
		build_table();
		repeat (4) @(posedge clk);
		rst_b <= 1'b1;
		@(posedge clk);
		for (int i = 0; i < rows.size(); i++) begin
			insn_2a <= rows[i].insn;
			pc_2a <= rows[i].pc;
			cpsr_2a <= rows[i].cpsr;
			spsr_2a <= rows[i].spsr;
			op0_2a <= rows[i].op0;
			op1_2a <= rows[i].op1;
			op2_2a <= rows[i].op2;
			carry_2a <= rows[i].carry;
			bubble_2a <= rows[i].bubble;
			flush_2a <= rows[i].flush;
			cnt = 0;
			stall_over = 1'b0;
			while (!stall_over && cnt < WAIT_LIMIT) begin
				@(negedge clk);
				if (!outstall_2a)
					stall_over = 1'b1;
				else begin
					@(posedge clk);
					cnt++;
					if (rows[i].late_flush)
						flush_2a <= (cnt == 1);
				end
			end
			@(posedge clk); // the 3a record is captured on this edge
			drive_idle();
			test_id <= i;
			timed_out <= !stall_over;
			stalled <= (cnt > 0);
			exp_row <= rows[i];
			compare <= 1'b1;
			@(posedge clk);
			compare <= 1'b0;
		end
		@(posedge clk);
		$display("tests run %0d, tests failed %0d", test_count, error_count);
		if (error_count == 0 && test_count == rows.size())
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
